//--- verilog.f
hdl/prom_pkg.sv
hdl/prom_apb_regs.sv
hdl/prom_blk_buf.sv
hdl/prom_cmd_seq.sv
hdl/prom_spi_shift.sv
hdl/prom_top.sv
dv/spi_flash_model.sv
dv/prom_tb.sv

//--- Makefile
# Verilator build for the PROM programmer

LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module prom_tb

sim:
	verilator --binary --timing -f verilog.f --top-module prom_tb -o prom_tb
	./obj_dir/prom_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "Simulation failed" $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/prom_tb.sv
/* PROM programmer testbench */

`timescale 1ns/1ps

module prom_tb import prom_pkg::*;;

    localparam int N_QUAD = 8;                      // Data quadlets per block

    logic                  clk = 1'b0;
    logic                  reset_n;
    logic [APB_ADDR_W-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    word_t                 pwdata;
    word_t                 prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  miso;
    logic                  sclk;
    logic                  mosi;
    logic                  cs_n;

    logic [7:0] ref_mem [1024];                     // Shadow of flash array
    logic [7:0] ref_st;
    logic       ref_dp;
    word_t      rng_state;

    prom_top prom_top_inst (
        .clk, .reset_n, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr, .miso, .sclk, .mosi, .cs_n
    );

    spi_flash_model flash_inst (.cs_n, .sclk, .mosi, .miso);

    always #10 clk = ~clk;

    function automatic word_t xorshift();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // Expected result of one register command, updates the shadow
    function automatic word_t flash_ref(input word_t cmd);
        logic [7:0] op;
        logic [9:0] a;
        word_t      r;
        op = cmd[31:24];
        a  = cmd[9:0];
        r  = '0;
        if (ref_dp && op != OP_RES)
            return '0;                              // Asleep, ignores all else
        case (op)
            OP_WREN: ref_st[1] = 1'b1;
            OP_WRDI: ref_st[1] = 1'b0;
            OP_RDID: r = 32'h0020_2015;
            OP_RDSR: r = {24'd0, ref_st};
            OP_READ, OP_FAST_READ: begin
                for (int k = 0; k < 4; k++) begin
                    r = {r[23:0], ref_mem[a]};
                    a = a + 1'b1;
                end
            end
            OP_WRSR: begin
                if (ref_st[1])
                    ref_st[7:2] = cmd[23:18];
                ref_st[1] = 1'b0;
            end
            OP_SE: begin
                if (ref_st[1])
                    for (int i = 0; i < 256; i++)
                        ref_mem[{a[9:8], 8'(i)}] = 8'hFF;
                ref_st[1] = 1'b0;
            end
            OP_BE: begin
                if (ref_st[1])
                    for (int i = 0; i < 1024; i++)
                        ref_mem[i] = 8'hFF;
                ref_st[1] = 1'b0;
            end
            OP_PP:  ref_st[1] = 1'b0;
            OP_DP:  ref_dp = 1'b1;
            OP_RES: begin
                ref_dp = 1'b0;
                r      = 32'h14;
            end
            default: ;
        endcase
        return r;
    endfunction

    // Page program with wrap inside the 256 byte page
    function automatic void ref_program(input logic [9:0] a, input word_t data[$]);
        word_t w;
        if (ref_st[1]) begin
            foreach (data[i]) begin
                w = data[i];
                for (int j = 0; j < 4; j++)
                    ref_mem[{a[9:8], a[7:0] + 8'(4 * i + j)}] &= w[31 - 8 * j -: 8];
            end
        end
        ref_st[1] = 1'b0;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp)
            stop_run($sformatf("Fail at %0d ns: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_err(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_run($sformatf("Fail at %0d ns: %s pslverr %b expected %b",
                               $time, what, got, exp));
    endtask

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input word_t data,
                             output logic err);
        @(posedge clk);
        paddr   <= addr;                            // Setup phase
        pwdata  <= data;
        pwrite  <= 1'b1;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;                              // Mid access cycle
        if (pready !== 1'b1)
            stop_run($sformatf("Fail at %0d ns: pready low in write access", $time));
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output word_t data);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        if (pready !== 1'b1)
            stop_run($sformatf("Fail at %0d ns: pready low in read access", $time));
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_idle();
        word_t st;
        int    polls;
        polls = 0;
        apb_read(REG_STATUS, st);
        while (st[ST_BUSY]) begin
            polls++;
            if (polls > 2000)
                stop_run("The sequencer stayed busy and never finished its command");
            apb_read(REG_STATUS, st);
        end
    endtask

    task automatic write_ok(input logic [APB_ADDR_W-1:0] addr, input word_t data);
        logic err;
        apb_write(addr, data, err);
        check_err(err, 1'b0, "register write");
    endtask

    // One register command, checked against the reference
    task automatic run_cmd(input word_t cmd, input string what);
        word_t res;
        write_ok(REG_CMD, cmd);
        wait_idle();
        apb_read(REG_RESULT, res);
        check_word(res, flash_ref(cmd), what);
    endtask

    initial begin
        repeat (20000) @(posedge clk);              // All tests need well under this
        stop_run("Timeout, the simulation hung before all tests completed");
    end

    initial begin
        word_t      data_q[$];
        word_t      res;
        logic [9:0] base;
        logic       err;
        rng_state = 32'd7;
        for (int i = 0; i < 1024; i++)
            ref_mem[i] = 8'hFF;
        ref_st  = 8'h00;
        ref_dp  = 1'b0;
        reset_n = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;

        run_cmd({OP_RDID, 24'd0}, "read ID");

        run_cmd({OP_WREN, 24'd0}, "write enable");
        run_cmd({OP_RDSR, 24'd0}, "status after write enable");
        run_cmd({OP_WRDI, 24'd0}, "write disable");
        run_cmd({OP_RDSR, 24'd0}, "status after write disable");

        // Block write to a random quadlet aligned spot that stays in its page
        base = {2'(xorshift() % 4), 8'(4 * (xorshift() % (64 - N_QUAD)))};
        run_cmd({OP_WREN, 24'd0}, "write enable before program");
        write_ok(REG_BLK_CTRL, 32'd1);
        write_ok(REG_BLK_BASE, {OP_PP, 14'd0, base});
        for (int i = 0; i < N_QUAD; i++) begin
            data_q.push_back(xorshift());
            write_ok(REG_BLK_BASE + 10'(4 * (i + 1)), data_q[i]);
        end
        write_ok(REG_BLK_CTRL, 32'd2);
        wait_idle();
        apb_read(REG_RESULT, res);
        check_word(res, N_QUAD + 1, "block quadlet count");
        ref_program(base, data_q);
        for (int i = 0; i < N_QUAD; i++) begin
            run_cmd({OP_READ, 14'd0, base + 10'(4 * i)}, "read back");
            run_cmd({OP_FAST_READ, 14'd0, base + 10'(4 * i)}, "fast read back");
        end

        // Sector erase
        run_cmd({OP_WREN, 24'd0}, "write enable before erase");
        run_cmd({OP_SE, 14'd0, base}, "sector erase");
        run_cmd({OP_READ, 14'd0, base}, "read after erase");
        apb_read(REG_RESULT, res);
        check_word(res, 32'hFFFF_FFFF, "erased quadlet");

        // Command while busy is refused, running one finishes untouched
        write_ok(REG_CMD, {OP_RDID, 24'd0});
        apb_write(REG_CMD, {OP_WREN, 24'd0}, err);
        check_err(err, 1'b1, "command while busy");
        wait_idle();
        apb_read(REG_RESULT, res);
        check_word(res, flash_ref({OP_RDID, 24'd0}), "ID after refused command");

        // Out of order block index, offered 2 with 1 expected
        write_ok(REG_BLK_CTRL, 32'd1);
        write_ok(REG_BLK_BASE, 32'h0);              // Null opcode, flash ignores it
        apb_write(REG_BLK_BASE + 10'd8, 32'h0, err);
        check_err(err, 1'b1, "out of order block index");
        apb_read(REG_STATUS, res);
        check_word(res, 32'h0201_000F, "status with block error");
        write_ok(REG_BLK_CTRL, 32'd2);
        wait_idle();
        apb_read(REG_RESULT, res);
        check_word(res, 32'd1, "block count after bad index");
        apb_write(REG_BLK_BASE, 32'h0, err);
        check_err(err, 1'b1, "block write with no block open");

        run_cmd({OP_DP, 24'd0}, "deep power down");
        run_cmd({OP_RES, 24'd0}, "release with old ID");

        $display("Simulation passed");
        $finish;
    end

endmodule

//--- dv/spi_flash_model.sv
/* Behavioral serial flash */

`timescale 1ns/1ps

module spi_flash_model import prom_pkg::*; (
    input  logic cs_n,
    input  logic sclk,
    input  logic mosi,
    output logic miso
);

    logic [7:0]  mem [1024];                        // 1 KiB, four 256 byte sectors
    logic [7:0]  st;                                // Status, bit 1 is write enable latch
    logic        dp;                                // Deep power down
    logic [7:0]  opcode;
    logic [23:0] addr;
    logic [31:0] in_sr;
    logic        miso_q = 1'b0;
    int          bit_cnt;

    assign miso = miso_q;

    initial begin
        for (int i = 0; i < 1024; i++)
            mem[i] = 8'hFF;                         // Erased part
        st      = 8'h00;
        dp      = 1'b0;
        opcode  = 8'h00;
        addr    = '0;
        in_sr   = '0;
        bit_cnt = 0;
    end

    // Bits before the reply starts, 0 when nothing is returned
    function automatic int reply_start();
        case (opcode)
            OP_RDID, OP_RDSR:  return 8;
            OP_READ, OP_RES:   return 32;
            OP_FAST_READ:      return 40;           // Dummy byte
            default:           return 0;
        endcase
    endfunction

    function automatic logic [7:0] reply_byte(input int idx);
        case (opcode)
            OP_RDID:               return (idx == 2) ? 8'h15 : 8'h20;
            OP_RDSR:               return st;
            OP_READ, OP_FAST_READ: return mem[10'(addr[9:0] + idx)];
            OP_RES:                return 8'h14;    // Old style ID
            default:               return 8'h00;
        endcase
    endfunction

    // Rising sclk shifts in, rising cs_n ends the frame
    always @(posedge sclk or posedge cs_n) begin
        if (cs_n) begin
            case (opcode)
                OP_WREN: st[1] = 1'b1;
                OP_WRDI: st[1] = 1'b0;
                OP_WRSR: begin
                    if (st[1] && bit_cnt >= 16)
                        st[7:2] = in_sr[7:2];
                    st[1] = 1'b0;
                end
                OP_SE: begin
                    if (st[1])
                        for (int i = 0; i < 256; i++)
                            mem[{addr[9:8], 8'(i)}] = 8'hFF;
                    st[1] = 1'b0;
                end
                OP_BE: begin
                    if (st[1])
                        for (int i = 0; i < 1024; i++)
                            mem[i] = 8'hFF;
                    st[1] = 1'b0;
                end
                OP_PP:  st[1] = 1'b0;
                OP_DP:  dp = 1'b1;
                OP_RES: dp = 1'b0;
                default: ;
            endcase
            opcode  = 8'h00;
            bit_cnt = 0;
        end else begin
            in_sr   = {in_sr[30:0], mosi};
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 8)                       // Only release wakes a sleeping part
                opcode = (dp && in_sr[7:0] != OP_RES) ? 8'h00 : in_sr[7:0];
            if (bit_cnt == 32)
                addr = in_sr[23:0];
            if (opcode == OP_PP && st[1] && bit_cnt > 32 && bit_cnt % 8 == 0)
                mem[{addr[9:8], addr[7:0] + 8'((bit_cnt - 40) / 8)}] &= in_sr[7:0];
        end
    end

    // Mode 0 reply changes on falling sclk
    always @(negedge sclk) begin
        int         k;
        logic [7:0] b;
        k = bit_cnt - reply_start();
        if (cs_n === 1'b0 && reply_start() != 0 && k >= 0) begin
            b      = reply_byte(k / 8);
            miso_q = b[7 - (k % 8)];
        end else begin
            miso_q = 1'b0;
        end
    end

endmodule

//--- hdl/prom_top.sv
/* Serial PROM programmer top */

`timescale 1ns/1ps

module prom_top import prom_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  word_t                 pwdata,
    output word_t                 prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  miso,
    output logic                  sclk,
    output logic                  mosi,
    output logic                  cs_n
);

    logic     cmd_valid;
    word_t    cmd_word;
    logic     blk_start;
    logic     blk_end;
    logic     busy;
    word_t    result;
    logic     buf_wen;
    blk_idx_t buf_addr;
    word_t    buf_wdata;
    logic     addr_ok;
    blk_idx_t blk_err_addr;
    blk_idx_t wr_count;
    blk_idx_t rd_idx;
    word_t    rd_data;
    logic     rd_en;
    logic     start;
    word_t    tx_word;
    cnt_t     send_cnt;
    cnt_t     recv_cnt;
    logic     done;
    word_t    rx_word;

    prom_apb_regs regs_inst (
        .clk, .reset_n, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr, .busy, .cs_n, .result, .addr_ok,
        .blk_err_addr, .cmd_valid, .cmd_word, .blk_start, .blk_end,
        .buf_wen, .buf_addr, .buf_wdata
    );

    prom_blk_buf buf_inst (
        .clk, .reset_n, .clear(blk_start), .buf_wen, .buf_addr, .buf_wdata,
        .rd_en, .addr_ok, .wr_count, .rd_idx, .rd_data, .blk_err_addr
    );

    prom_cmd_seq seq_inst (
        .clk, .reset_n, .cmd_valid, .cmd_word, .blk_start, .blk_end,
        .wr_count, .rd_idx, .rd_data, .done, .rx_word, .busy, .cs_n,
        .result, .rd_en, .start, .tx_word, .send_cnt, .recv_cnt
    );

    prom_spi_shift spi_inst (
        .clk, .reset_n, .start, .tx_word, .send_cnt, .recv_cnt, .miso,
        .sclk, .mosi, .done, .rx_word
    );

endmodule

//--- hdl/prom_spi_shift.sv
/* SPI mode 0 shifter */

`timescale 1ns/1ps

module prom_spi_shift import prom_pkg::*; (
    input  logic  clk,
    input  logic  reset_n,
    input  logic  start,
    input  word_t tx_word,
    input  cnt_t  send_cnt,
    input  cnt_t  recv_cnt,
    input  logic  miso,
    output logic  sclk,
    output logic  mosi,
    output logic  done,
    output word_t rx_word
);

    logic  sending;
    logic  receiving;
    cnt_t  seqn;                                    // Half-period count, bit 0 is sclk
    cnt_t  send_last;
    cnt_t  recv_last;
    word_t sr;                                      // Outgoing bits, MSB first

    assign sclk = seqn[0];
    assign mosi = sr[31];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            sending   <= 1'b0;
            receiving <= 1'b0;
            seqn      <= '0;
            done      <= 1'b0;
            sr        <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                sending <= 1'b1;
                seqn    <= '0;
                sr      <= tx_word;
            end else if (sending) begin
                if (seqn[0])
                    sr <= {sr[30:0], 1'b0};         // Advance after high phase
                if (seqn == send_last) begin
                    seqn      <= '0;
                    sending   <= 1'b0;
                    receiving <= (recv_last != '0);
                    done      <= (recv_last == '0);
                end else begin
                    seqn <= seqn + 1'b1;
                end
            end else if (receiving) begin
                if (seqn == recv_last) begin
                    seqn      <= '0;
                    receiving <= 1'b0;
                    done      <= 1'b1;
                end else begin
                    seqn <= seqn + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            send_last <= send_cnt;
            recv_last <= recv_cnt;
            rx_word   <= '0;
        end else if (receiving && !seqn[0]) begin
            rx_word <= {rx_word[30:0], miso};       // Sample before rising edge
        end
    end

endmodule

//--- hdl/prom_cmd_seq.sv
/* PROM command sequencer */

`timescale 1ns/1ps

module prom_cmd_seq import prom_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     cmd_valid,
    input  word_t    cmd_word,
    input  logic     blk_start,
    input  logic     blk_end,
    input  blk_idx_t wr_count,
    input  blk_idx_t rd_idx,
    input  word_t    rd_data,
    input  logic     done,
    input  word_t    rx_word,
    output logic     busy,
    output logic     cs_n,
    output word_t    result,
    output logic     rd_en,
    output logic     start,
    output word_t    tx_word,
    output cnt_t     send_cnt,
    output cnt_t     recv_cnt
);

    seq_state_t state;
    logic       blk_mode;                           // Current frame is a block write
    logic       blk_open;
    logic       op_known;
    cnt_t       op_send;
    cnt_t       op_recv;
    logic       cmd_go;
    logic       blk_go;                             // Next quadlet ready

    assign busy   = (state != IDLE);
    assign cmd_go = (state == IDLE) && cmd_valid && op_known;
    assign blk_go = (state == SELECT) && blk_mode && (rd_idx != wr_count);

    // Counts are 2*bits-1, receive 0 means nothing to read
    always_comb begin
        op_known = 1'b1;
        op_send  = 7'd15;
        op_recv  = 7'd0;
        case (cmd_word[31:24])
            OP_WREN, OP_WRDI, OP_BE, OP_DP: ;       // Opcode only
            OP_RDID:      op_recv = 7'd47;          // 3 ID bytes
            OP_RDSR:      op_recv = 7'd15;
            OP_WRSR:      op_send = 7'd31;          // Opcode plus status byte
            OP_READ: begin
                op_send = 7'd63;
                op_recv = 7'd63;                    // One quadlet
            end
            OP_FAST_READ: begin
                op_send = 7'd79;                    // Dummy byte after address
                op_recv = 7'd63;
            end
            OP_PP, OP_SE: op_send = 7'd63;          // Address only, PP data via block
            OP_RES: begin
                op_send = 7'd63;                    // 3 dummy bytes
                op_recv = 7'd15;                    // Old style ID
            end
            default:      op_known = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state    <= IDLE;
            cs_n     <= 1'b1;
            start    <= 1'b0;
            rd_en    <= 1'b0;
            blk_mode <= 1'b0;
            blk_open <= 1'b0;
            result   <= '0;
        end else begin
            start <= 1'b0;
            rd_en <= 1'b0;
            if (blk_start)
                blk_open <= 1'b1;
            else if (blk_end)
                blk_open <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd_go) begin
                        cs_n     <= 1'b0;
                        blk_mode <= 1'b0;
                        state    <= SELECT;
                    end else if (cmd_valid) begin
                        result <= '0;               // Unknown opcode
                    end else if (blk_start) begin
                        cs_n     <= 1'b0;           // Hold select for whole block
                        blk_mode <= 1'b1;
                        result   <= '0;
                        state    <= SELECT;
                    end
                end
                SELECT: begin
                    if (!blk_mode) begin
                        start <= 1'b1;
                        state <= XFER;
                    end else if (blk_go) begin
                        start <= 1'b1;
                        rd_en <= 1'b1;
                        state <= BLK_XFER;
                    end else if (!blk_open) begin
                        result <= {25'd0, rd_idx};  // Quadlets sent
                        state  <= DESELECT;
                    end
                end
                XFER: begin
                    if (done) begin
                        result <= rx_word;
                        state  <= DESELECT;
                    end
                end
                BLK_XFER: begin
                    if (done)
                        state <= SELECT;            // Look for next quadlet
                end
                DESELECT: begin
                    cs_n  <= 1'b1;
                    state <= RELEASE;
                end
                RELEASE:  state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_go) begin
            tx_word  <= cmd_word;
            send_cnt <= op_send;
            recv_cnt <= op_recv;
        end else if (blk_go) begin
            tx_word  <= rd_data;
            send_cnt <= 7'd63;                      // Full quadlet, no reply
            recv_cnt <= 7'd0;
        end
    end

endmodule

//--- hdl/prom_blk_buf.sv
/* Block write quadlet buffer */

`timescale 1ns/1ps

module prom_blk_buf import prom_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     clear,
    input  logic     buf_wen,
    input  blk_idx_t buf_addr,
    input  word_t    buf_wdata,
    input  logic     rd_en,
    output logic     addr_ok,
    output blk_idx_t wr_count,
    output blk_idx_t rd_idx,
    output word_t    rd_data,
    output blk_idx_t blk_err_addr
);

    word_t mem [BLK_DEPTH];
    logic  wr_ok;

    // Only the next sequential slot is accepted, full buffer never matches
    assign addr_ok      = (buf_addr == wr_count);
    assign wr_ok        = buf_wen & addr_ok;
    assign blk_err_addr = addr_ok ? '0 : wr_count;  // Expected index on mismatch
    assign rd_data      = mem[rd_idx[BLK_AW-1:0]];

    always_ff @(posedge clk) begin
        if (wr_ok)
            mem[wr_count[BLK_AW-1:0]] <= buf_wdata;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_count <= '0;
            rd_idx   <= '0;
        end else if (clear) begin
            wr_count <= '0;                         // New block
            rd_idx   <= '0;
        end else begin
            if (wr_ok)
                wr_count <= wr_count + 1'b1;
            if (rd_en)
                rd_idx <= rd_idx + 1'b1;            // Sequencer took one quadlet
        end
    end

endmodule

//--- hdl/prom_apb_regs.sv
/* PROM programmer APB registers */

`timescale 1ns/1ps

module prom_apb_regs import prom_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  word_t                 pwdata,
    output word_t                 prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  busy,
    input  logic                  cs_n,
    input  word_t                 result,
    input  logic                  addr_ok,
    input  blk_idx_t              blk_err_addr,
    output logic                  cmd_valid,
    output word_t                 cmd_word,
    output logic                  blk_start,
    output logic                  blk_end,
    output logic                  buf_wen,
    output blk_idx_t              buf_addr,
    output word_t                 buf_wdata
);

    logic        wr_acc;                            // Write in access phase
    logic        is_cmd;
    logic        is_ctrl;
    logic        is_blk;                            // Inside buffer window
    logic        cmd_err;
    logic        blk_wr_err;
    logic        cmd_ok;
    logic        blk_open;
    logic        blk_err;                           // Sticky until next block
    logic [15:0] dbg;                               // First bad offered/expected pair
    word_t       status;

    assign wr_acc     = psel & penable & pwrite;
    assign is_cmd     = (paddr == REG_CMD);
    assign is_ctrl    = (paddr == REG_BLK_CTRL);
    assign is_blk     = (paddr[APB_ADDR_W-1:8] == REG_BLK_BASE[APB_ADDR_W-1:8]);
    assign buf_addr   = {1'b0, paddr[7:2]};         // Quadlet index in window
    assign buf_wdata  = pwdata;
    assign cmd_err    = busy | cmd_valid;           // Command still launching counts too
    assign blk_wr_err = ~blk_open | ~addr_ok;
    assign cmd_ok     = wr_acc & is_cmd & ~cmd_err;
    assign buf_wen    = wr_acc & is_blk & ~blk_wr_err;
    assign pready     = 1'b1;                       // No wait states
    assign pslverr    = wr_acc & ((is_cmd & cmd_err) | (is_blk & blk_wr_err));

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            cmd_valid <= 1'b0;
            blk_start <= 1'b0;
            blk_end   <= 1'b0;
            blk_open  <= 1'b0;
            blk_err   <= 1'b0;
            dbg       <= '0;
        end else begin
            cmd_valid <= cmd_ok;
            blk_start <= 1'b0;
            blk_end   <= 1'b0;
            if (wr_acc && is_ctrl && pwdata == 32'd1 && !blk_open && !busy) begin
                blk_start <= 1'b1;                  // Open, clear error record
                blk_open  <= 1'b1;
                blk_err   <= 1'b0;
                dbg       <= '0;
            end else if (wr_acc && is_ctrl && pwdata == 32'd2 && blk_open) begin
                blk_end  <= 1'b1;
                blk_open <= 1'b0;
            end
            if (wr_acc && is_blk && blk_open && !addr_ok) begin
                blk_err <= 1'b1;
                if (!blk_err)
                    dbg <= {1'b0, buf_addr, 1'b0, blk_err_addr};  // Keep first only
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_ok)
            cmd_word <= pwdata;
    end

    always_comb begin
        status              = '0;
        status[31:16]       = dbg;
        status[ST_BUSY]     = busy;
        status[ST_BLK_OPEN] = blk_open;
        status[ST_BLK_ERR]  = blk_err;
        status[ST_CS]       = ~cs_n;                // Chip selected
    end

    always_comb begin
        case (paddr)
            REG_CMD:      prdata = cmd_word;
            REG_STATUS:   prdata = status;
            REG_RESULT:   prdata = result;
            REG_BLK_CTRL: prdata = {30'd0, blk_err, blk_open};
            default:      prdata = '0;
        endcase
    end

endmodule

//--- hdl/prom_pkg.sv
/* Serial PROM programmer shared definitions */

package prom_pkg;

    localparam int APB_ADDR_W = 10;                 // Covers regs and buffer window
    localparam int CNT_W      = 7;                  // Half-period counter width
    localparam int BLK_DEPTH  = 64;                 // Quadlets per block
    localparam int BLK_AW     = 6;                  // Buffer memory address width

    typedef logic [31:0]       word_t;              // APB and SPI quadlet
    typedef logic [CNT_W-1:0]  cnt_t;               // 2*bits-1
    typedef logic [BLK_AW:0]   blk_idx_t;           // One extra bit so 64 fits

    // Flash opcodes
    localparam logic [7:0] OP_WREN      = 8'h06;
    localparam logic [7:0] OP_WRDI      = 8'h04;
    localparam logic [7:0] OP_RDID      = 8'h9F;
    localparam logic [7:0] OP_RDSR      = 8'h05;
    localparam logic [7:0] OP_WRSR      = 8'h01;
    localparam logic [7:0] OP_READ      = 8'h03;
    localparam logic [7:0] OP_FAST_READ = 8'h0B;
    localparam logic [7:0] OP_PP        = 8'h02;
    localparam logic [7:0] OP_SE        = 8'hD8;
    localparam logic [7:0] OP_BE        = 8'hC7;
    localparam logic [7:0] OP_DP        = 8'hB9;
    localparam logic [7:0] OP_RES       = 8'hAB;

    // Register map
    localparam logic [APB_ADDR_W-1:0] REG_CMD      = 10'h000;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS   = 10'h004;
    localparam logic [APB_ADDR_W-1:0] REG_RESULT   = 10'h008;
    localparam logic [APB_ADDR_W-1:0] REG_BLK_CTRL = 10'h00C;
    localparam logic [APB_ADDR_W-1:0] REG_BLK_BASE = 10'h100;  // 64 quadlets up to 0x1FC

    // Status bits, debug index pair in [31:16]
    localparam int ST_BUSY     = 0;
    localparam int ST_BLK_OPEN = 1;
    localparam int ST_BLK_ERR  = 2;
    localparam int ST_CS       = 3;

    typedef enum logic [2:0] {IDLE, SELECT, XFER, BLK_XFER, DESELECT, RELEASE} seq_state_t;

endpackage
